// File: bench/nlc_tb_tasks.svh
`ifndef NLC_TB_TASKS_SVH
`define NLC_TB_TASKS_SVH

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd13;

function automatic logic rand_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], rand_bit()};
  end
  return v;
endfunction

// n random bits, sign extended
function automatic logic [31:0] rand_signed(input int n);
  logic [31:0] v;
  v = rand_bits(n);
  if (v[n-1]) begin
    v = v | ~((32'd1 << n) - 32'd1);
  end
  return v;
endfunction

task automatic wait_pready(input string what);
  int waited;
  waited = 0;
  @(negedge clk);
  while (apb_rsp.pready !== 1'b1 && waited < PREADY_LIMIT) begin
    @(negedge clk);
    waited++;
  end
  if (apb_rsp.pready !== 1'b1) begin
    fail_run({what, " timed out waiting for pready"});
  end
endtask

task automatic apb_write(input int word, input logic [31:0] data);
  next_cycle();
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b1;
  apb_req.paddr   = {word[6:0], 2'b00};
  apb_req.pwdata  = data;
  next_cycle();
  apb_req.penable = 1'b1;
  wait_pready("APB write");
  next_cycle();
  apb_req.psel    = 1'b0;
  apb_req.penable = 1'b0;
endtask

task automatic apb_read(input int word, output logic [31:0] data, output logic err);
  next_cycle();
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b0;
  apb_req.paddr   = {word[6:0], 2'b00};
  apb_req.pwdata  = '0;
  next_cycle();
  apb_req.penable = 1'b1;
  wait_pready("APB read");
  data = apb_rsp.prdata;
  err  = apb_rsp.pslverr;
  next_cycle();
  apb_req.psel    = 1'b0;
  apb_req.penable = 1'b0;
endtask

// Q15.16 product, bits 47:16 of the sign-extended 64-bit product
function automatic logic [31:0] fixed_mul(input logic [31:0] a, input logic [31:0] b);
  logic signed [63:0] wide_a;
  logic signed [63:0] wide_b;
  logic signed [63:0] prod;
  wide_a = {{32{a[31]}}, a};
  wide_b = {{32{b[31]}}, b};
  prod = wide_a * wide_b;
  return prod[47:16];
endfunction

function automatic nlc_pkg::adc_code_t model_code(input nlc_pkg::ch_idx_t ch,
                                                  input nlc_pkg::adc_code_t code);
  int base;
  logic [31:0] off;
  logic [31:0] x;
  logic [31:0] acc;
  logic signed [31:0] whole;
  nlc_pkg::adc_code_t out;
  base = int'(ch) * `NLC_CAL_WORDS;
  off = ({11'b0, code} << 16) + cal_words[base];
  x = fixed_mul(off, cal_words[base+1]);
  acc = cal_words[base+7];
  // Horner from coeff[4] down to coeff[0]
  for (int k = 4; k >= 0; k--) begin
    acc = fixed_mul(acc, x) + cal_words[base+2+k];
  end
  whole = $signed(acc) >>> 16;
  if (whole < 0) begin
    out = '0;
  end else if (whole > 32'sd2097151) begin
    out = '1;
  end else begin
    out = whole[20:0];
  end
  return out;
endfunction

`endif

// File: bench/nlc_tb.sv
`include "nlc_defines.svh"

module nlc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] ONE = 32'h0001_0000;
  localparam int CAL_TOTAL = `NLC_CHANNELS * `NLC_CAL_WORDS;
  localparam int DRAIN_LIMIT = 64;
  localparam int PREADY_LIMIT = 16;

  // Expected result with the cycle its sample was taken
  typedef struct packed {
    nlc_pkg::ch_idx_t ch;
    nlc_pkg::adc_code_t code;
    logic [31:0] taken;
  } expect_t;

  logic clk;
  logic rst;
  nlc_pkg::apb_req_t apb_req;
  nlc_pkg::apb_rsp_t apb_rsp;
  nlc_pkg::sample_t sample;
  nlc_pkg::result_t result;

  logic [31:0] cal_words [CAL_TOTAL];
  logic [31:0] cycle_count = 32'd0;
  expect_t expect_q [$];

  nlc_corrector dut_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .sample  (sample),
    .result  (result)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 32'd1;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      fail_run($sformatf("[FAIL] %0t %s expected 0x%0h actual 0x%0h",
                         $time, name, expected, actual));
    end
  endtask

  `include "nlc_tb_tasks.svh"

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      next_cycle();
      sample.valid = 1'b0;
    end
  endtask

  task automatic send_sample(input nlc_pkg::ch_idx_t ch, input nlc_pkg::adc_code_t code,
                             input nlc_pkg::adc_code_t expected);
    expect_t item;
    next_cycle();
    sample.valid = 1'b1;
    sample.ch    = ch;
    sample.code  = code;
    item.ch    = ch;
    item.code  = expected;
    item.taken = cycle_count;
    expect_q.push_back(item);
  endtask

  task automatic write_cal(input int ch, input int field, input logic [31:0] value);
    apb_write(ch * `NLC_CAL_WORDS + field, value);
    cal_words[ch * `NLC_CAL_WORDS + field] = value;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      fail_run("Timed out waiting for outstanding results");
    end
  endtask

  // Small values keep the polynomial mostly inside Q15.16
  function automatic logic [31:0] small_cal_word(input int field);
    logic [31:0] v;
    case (field)
      0: v = 32'd0 - (rand_bits(14) << 16);
      1: v = rand_bits(4) + 32'd1;
      2: v = rand_bits(26);
      default: v = rand_signed(10);
    endcase
    return v;
  endfunction

  // Results in order, tag kept, fixed latency, no strays
  always @(negedge clk) begin
    expect_t exp_item;
    if (!rst && result.valid === 1'b1) begin
      if (expect_q.size() == 0) begin
        fail_run("Result valid seen with no sample outstanding");
      end else begin
        exp_item = expect_q.pop_front();
        check_value("result.ch", 32'(exp_item.ch), 32'(result.ch));
        check_value("result.code", 32'(exp_item.code), 32'(result.code));
        check_value("result latency", 32'd8, cycle_count - exp_item.taken);
      end
    end
  end

  initial begin
    logic [31:0] data;
    logic err;
    nlc_pkg::ch_idx_t ch;
    nlc_pkg::adc_code_t code;

    clk = 1'b0;
    rst = 1'b1;
    apb_req = '0;
    sample = '0;
    for (int w = 0; w < CAL_TOTAL; w++) begin
      cal_words[w] = 32'd0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_value("result.valid", 32'd0, 32'(result.valid));
    for (int w = 0; w < CAL_TOTAL; w++) begin
      apb_read(w, data, err);
      check_value("prdata", 32'd0, data);
      check_value("pslverr", 32'd0, 32'(err));
    end

    // Nine address bits reach only 128 words so every access decodes in range
    for (int w = 0; w < CAL_TOTAL; w++) begin
      write_cal(w / `NLC_CAL_WORDS, w % `NLC_CAL_WORDS, rand_bits(32));
    end
    for (int w = 0; w < CAL_TOTAL; w++) begin
      apb_read(w, data, err);
      check_value("prdata", cal_words[w], data);
      check_value("pslverr", 32'd0, 32'(err));
    end

    // Identity path with codes that fit Q15.16
    for (int c = 0; c < `NLC_CHANNELS; c++) begin
      for (int f = 0; f < `NLC_CAL_WORDS; f++) begin
        write_cal(c, f, (f == 1 || f == 3) ? ONE : 32'd0);
      end
    end
    for (int n = 0; n < 48; n++) begin
      ch = nlc_pkg::ch_idx_t'(rand_bits(4));
      code = nlc_pkg::adc_code_t'(rand_bits(15));
      send_sample(ch, code, code);
    end
    idle(1);
    wait_results();

    for (int c = 0; c < `NLC_CHANNELS; c++) begin
      for (int f = 0; f < `NLC_CAL_WORDS; f++) begin
        write_cal(c, f, small_cal_word(f));
      end
    end
    for (int n = 0; n < 200; n++) begin
      ch = nlc_pkg::ch_idx_t'(rand_bits(4));
      code = nlc_pkg::adc_code_t'(rand_bits(15));
      send_sample(ch, code, model_code(ch, code));
    end
    idle(1);
    wait_results();

    // Channel 0 gives -x, channel 1 the largest accumulator
    // Q15.16 tops out at 32767 which is below the code ceiling
    for (int f = 0; f < `NLC_CAL_WORDS; f++) begin
      write_cal(0, f, (f == 1) ? ONE : ((f == 3) ? 32'hFFFF_0000 : 32'd0));
      write_cal(1, f, (f == 1) ? ONE : ((f == 2) ? 32'h7FFF_FFFF : 32'd0));
    end
    for (int n = 0; n < 16; n++) begin
      code = nlc_pkg::adc_code_t'(rand_bits(15) | 32'd1);
      send_sample(nlc_pkg::ch_idx_t'(n % 2), code,
                  (n % 2 == 0) ? '0 : nlc_pkg::adc_code_t'(32767));
    end
    idle(1);
    wait_results();

    // Idle gaps between samples
    for (int n = 0; n < 40; n++) begin
      idle(int'(rand_bits(2)));
      ch = nlc_pkg::ch_idx_t'(rand_bits(4));
      code = nlc_pkg::adc_code_t'(rand_bits(15));
      send_sample(ch, code, model_code(ch, code));
    end
    idle(1);
    wait_results();
    idle(24);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: nlc_corrector.f
+incdir+verilog
+incdir+bench
verilog/nlc_pkg.sv
verilog/nlc_cal_regs.sv
verilog/nlc_normalizer.sv
verilog/nlc_horner_stage.sv
verilog/nlc_output_clamp.sv
verilog/nlc_corrector.sv
bench/nlc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the corrector testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  -f nlc_corrector.f --top-module nlc_tb -Mdir "$OBJ" -o nlc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/nlc_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

// File: verilog/nlc_cal_regs.sv
`include "nlc_defines.svh"

module nlc_cal_regs (
  input  logic                clk,
  input  logic                rst,
  input  nlc_pkg::apb_req_t   apb_req,
  output nlc_pkg::apb_rsp_t   apb_rsp,
  output nlc_pkg::chan_cal_t  cal_table [`NLC_CHANNELS]
);

  localparam int FIELD_BITS = $clog2(`NLC_CAL_WORDS);

  nlc_pkg::fixed_t cal_mem [`NLC_CHANNELS][`NLC_CAL_WORDS];

  logic [`NLC_APB_ADDR_BITS-3:0] word_addr;
  nlc_pkg::ch_idx_t word_ch;
  logic [FIELD_BITS-1:0] word_field;
  logic access;
  logic bad_addr;
  logic wr_en;

  // Byte address to word, then channel and field
  assign word_addr  = apb_req.paddr[`NLC_APB_ADDR_BITS-1:2];
  assign word_ch    = nlc_pkg::ch_idx_t'(word_addr >> FIELD_BITS);
  assign word_field = word_addr[FIELD_BITS-1:0];

  assign access   = apb_req.psel & apb_req.penable;
  assign bad_addr = 32'(word_addr) >= (`NLC_CHANNELS * `NLC_CAL_WORDS);
  assign wr_en    = access & apb_req.pwrite & ~bad_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < `NLC_CHANNELS; c++) begin
        for (int f = 0; f < `NLC_CAL_WORDS; f++) begin
          cal_mem[c][f] <= '0;
        end
      end
    end else if (wr_en) begin
      cal_mem[word_ch][word_field] <= apb_req.pwdata;
    end
  end

  // Zero wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & bad_addr;

  always_comb begin
    apb_rsp.prdata = '0;
    if (access && !bad_addr) begin
      apb_rsp.prdata = cal_mem[word_ch][word_field];
    end
  end

  // Field 0 mean, field 1 stdev, fields 2..7 coeff[0..5]
  always_comb begin
    for (int c = 0; c < `NLC_CHANNELS; c++) begin
      cal_table[c].neg_mean    = cal_mem[c][0];
      cal_table[c].recip_stdev = cal_mem[c][1];
      for (int k = 0; k <= `NLC_ORDER; k++) begin
        cal_table[c].coeff[k] = cal_mem[c][k+2];
      end
    end
  end

endmodule

// File: verilog/nlc_corrector.sv
`include "nlc_defines.svh"

module nlc_corrector (
  input  logic              clk,
  input  logic              rst,
  input  nlc_pkg::apb_req_t apb_req,
  output nlc_pkg::apb_rsp_t apb_rsp,
  input  nlc_pkg::sample_t  sample,
  output nlc_pkg::result_t  result
);

  nlc_pkg::chan_cal_t cal_table [`NLC_CHANNELS];

  // chain[0] from the normalizer, chain[ORDER] into the clamp
  nlc_pkg::stage_item_t chain [`NLC_ORDER+1];

  nlc_cal_regs cal_regs_i (
    .clk       (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .cal_table (cal_table)
  );

  nlc_normalizer normalizer_i (
    .clk       (clk),
    .rst       (rst),
    .sample    (sample),
    .cal_table (cal_table),
    .item      (chain[0])
  );

  // Horner steps for coeff[4] down to coeff[0]
  for (genvar i = 0; i < `NLC_ORDER; i++) begin : g_stage
    nlc_horner_stage #(
      .COEFF_IDX (`NLC_ORDER - 1 - i)
    ) stage_i (
      .clk       (clk),
      .rst       (rst),
      .item_in   (chain[i]),
      .cal_table (cal_table),
      .item_out  (chain[i+1])
    );
  end

  nlc_output_clamp output_clamp_i (
    .clk    (clk),
    .rst    (rst),
    .item   (chain[`NLC_ORDER]),
    .result (result)
  );

endmodule

// File: verilog/nlc_defines.svh
`ifndef NLC_DEFINES_SVH
`define NLC_DEFINES_SVH

// Channel count and index width
`define NLC_CHANNELS 16
`define NLC_CH_BITS 4

// Polynomial order, six coefficients per channel
`define NLC_ORDER 5

// ADC input and corrected output code width
`define NLC_ADC_BITS 21

// Signed fixed point, Q15.16
`define NLC_DATA_BITS 32
`define NLC_FRAC_BITS 16

// Calibration words per channel and APB byte address width
`define NLC_CAL_WORDS 8
`define NLC_APB_ADDR_BITS 9

`endif

// File: verilog/nlc_horner_stage.sv
`include "nlc_defines.svh"

module nlc_horner_stage #(
  parameter int COEFF_IDX = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  nlc_pkg::stage_item_t item_in,
  input  nlc_pkg::chan_cal_t   cal_table [`NLC_CHANNELS],
  output nlc_pkg::stage_item_t item_out
);

  nlc_pkg::fixed_t coeff;
  nlc_pkg::fixed_t acc_next;

  // Coefficient of this stage for the item's own channel
  assign coeff    = cal_table[item_in.ch].coeff[COEFF_IDX];
  assign acc_next = nlc_pkg::fx_mul(item_in.acc, item_in.xn) + coeff;

  always_ff @(posedge clk) begin
    item_out.ch  <= item_in.ch;
    item_out.xn  <= item_in.xn;
    item_out.acc <= acc_next;
    if (rst) begin
      item_out.valid <= 1'b0;
    end else begin
      item_out.valid <= item_in.valid;
    end
  end

endmodule

// File: verilog/nlc_normalizer.sv
`include "nlc_defines.svh"

module nlc_normalizer (
  input  logic                 clk,
  input  logic                 rst,
  input  nlc_pkg::sample_t     sample,
  input  nlc_pkg::chan_cal_t   cal_table [`NLC_CHANNELS],
  output nlc_pkg::stage_item_t item
);

  nlc_pkg::fixed_t code_fx;

  logic s1_valid;
  nlc_pkg::ch_idx_t s1_ch;
  nlc_pkg::fixed_t s1_offset;

  // Integer code moved up to the fixed-point grid
  assign code_fx = nlc_pkg::fixed_t'(sample.code) << `NLC_FRAC_BITS;

  // Step 1, remove the channel mean
  always_ff @(posedge clk) begin
    s1_ch     <= sample.ch;
    s1_offset <= code_fx + cal_table[sample.ch].neg_mean;
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= sample.valid;
    end
  end

  // Step 2, scale and seed the accumulator with the leading coefficient
  always_ff @(posedge clk) begin
    item.ch  <= s1_ch;
    item.xn  <= nlc_pkg::fx_mul(s1_offset, cal_table[s1_ch].recip_stdev);
    item.acc <= cal_table[s1_ch].coeff[`NLC_ORDER];
    if (rst) begin
      item.valid <= 1'b0;
    end else begin
      item.valid <= s1_valid;
    end
  end

endmodule

// File: verilog/nlc_output_clamp.sv
`include "nlc_defines.svh"

module nlc_output_clamp (
  input  logic                 clk,
  input  logic                 rst,
  input  nlc_pkg::stage_item_t item,
  output nlc_pkg::result_t     result
);

  localparam nlc_pkg::fixed_t CODE_MAX =
    nlc_pkg::fixed_t'((1 << `NLC_ADC_BITS) - 1);

  nlc_pkg::fixed_t whole;
  nlc_pkg::adc_code_t code;

  // Drop fraction bits, floor toward minus infinity
  assign whole = item.acc >>> `NLC_FRAC_BITS;

  always_comb begin
    if (whole < 0) begin
      code = '0;
    end else if (whole > CODE_MAX) begin
      code = '1;
    end else begin
      code = whole[`NLC_ADC_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    result.ch   <= item.ch;
    result.code <= code;
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= item.valid;
    end
  end

endmodule

// File: verilog/nlc_pkg.sv
`include "nlc_defines.svh"

package nlc_pkg;

  typedef logic [`NLC_ADC_BITS-1:0] adc_code_t;
  typedef logic signed [`NLC_DATA_BITS-1:0] fixed_t;
  typedef logic [`NLC_CH_BITS-1:0] ch_idx_t;

  // One channel's calibration, coeff[5] is the leading term
  typedef struct packed {
    fixed_t neg_mean;
    fixed_t recip_stdev;
    fixed_t [`NLC_ORDER:0] coeff;
  } chan_cal_t;

  // Item passed down the Horner chain
  typedef struct packed {
    logic valid;
    ch_idx_t ch;
    fixed_t xn;
    fixed_t acc;
  } stage_item_t;

  typedef struct packed {
    logic valid;
    ch_idx_t ch;
    adc_code_t code;
  } sample_t;

  typedef struct packed {
    logic valid;
    ch_idx_t ch;
    adc_code_t code;
  } result_t;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [`NLC_APB_ADDR_BITS-1:0] paddr;
    logic [`NLC_DATA_BITS-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`NLC_DATA_BITS-1:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  // Full product, drop the fraction bits, keep low word
  function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
    logic signed [2*`NLC_DATA_BITS-1:0] prod;
    prod = a * b;
    return fixed_t'(prod >>> `NLC_FRAC_BITS);
  endfunction

endpackage
